// ==== Bender.yml ====
package:
  name: intra_mode

sources:
  - common/intra_pkg.sv
  - hdl/intra_predict.sv
  - reconstruct/residual_quant.sv
  - hdl/block_metrics.sv
  - hdl/mode_picker.sv
  - hdl/intra_mode_top.sv
  - target: simulation
    files:
      - tb/tb_intra_mode.sv

// ==== common/intra_pkg.sv ====
/*
 * Intra mode decision shared definitions
 * Block geometry, datapath widths, mode codes, per-mode rate
 * costs and the request/result structs of the 4x4 luma engine
 */

package intra_pkg;

    localparam int blk_dim   = 4;
    localparam int num_pix   = blk_dim * blk_dim;
    localparam int num_modes = 4;
    localparam int pix_w     = 8;
    localparam int lvl_w     = 10;
    localparam int sse_w     = 20;
    localparam int rate_w    = 16;
    localparam int score_w   = 48;
    localparam int lambda_w  = 16;
    localparam int qshift_w  = 3;

    typedef enum logic [1:0] {
        mode_dc = 2'd0,
        mode_tm = 2'd1,
        mode_ve = 2'd2,
        mode_he = 2'd3
    } mode_t;

    // Rate cost added per mode, indexed by mode code
    localparam logic [15:0] fixed_cost [num_modes] = '{16'd663, 16'd919, 16'd872, 16'd919};

    typedef logic [num_pix-1:0][pix_w-1:0] pix_blk_t;
    typedef logic [num_pix-1:0][lvl_w-1:0] lvl_blk_t;

    typedef struct packed {
        pix_blk_t                        src;
        logic [blk_dim-1:0][pix_w-1:0]   top;
        logic [blk_dim-1:0][pix_w-1:0]   left;
        logic [pix_w-1:0]                top_left;
        logic [9:0]                      blk_x;
        logic [9:0]                      blk_y;
        logic [qshift_w-1:0]             qshift;
        logic [lambda_w-1:0]             lambda_mode;
        logic [lambda_w-1:0]             lambda_i16;
        logic [sse_w-1:0]                min_disto;
    } intra_req_t;

    typedef struct packed {
        mode_t                 mode;
        logic [score_w-1:0]    score;
        pix_blk_t              recon;
        lvl_blk_t              levels;
        logic [num_pix-1:0]    nz;
        logic [lvl_w-1:0]      max_edge;
    } intra_res_t;

    // Magnitude of a two's complement level
    function automatic logic [lvl_w-1:0] lvl_mag(input logic [lvl_w-1:0] lvl);
        return lvl[lvl_w-1] ? lvl_w'(-lvl) : lvl;
    endfunction

endpackage

// ==== flist.f ====
common/intra_pkg.sv
hdl/intra_predict.sv
reconstruct/residual_quant.sv
hdl/block_metrics.sv
hdl/mode_picker.sv
hdl/intra_mode_top.sv
tb/tb_intra_mode.sv

// ==== hdl/block_metrics.sv ====
/*
 * Block metrics
 * Two stage pipeline: squared pixel errors and level magnitudes,
 * then their sums as SSE and rate
 */

`timescale 1ns/1ns

module block_metrics (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  intra_pkg::pix_blk_t               src,
    input  intra_pkg::pix_blk_t               recon,
    input  intra_pkg::lvl_blk_t               levels,
    output logic [intra_pkg::sse_w-1:0]       sse,
    output logic [intra_pkg::rate_w-1:0]      rate,
    output logic                              done
);

    logic [intra_pkg::num_pix-1:0][2*intra_pkg::pix_w-1:0]  sq_q;
    logic [intra_pkg::num_pix-1:0][intra_pkg::lvl_w-1:0]    mag_q;
    logic                                                   s1_valid;
    logic [intra_pkg::sse_w-1:0]                            sse_sum;
    logic [intra_pkg::rate_w-1:0]                           rate_sum;

    function automatic logic [2*intra_pkg::pix_w-1:0] sq_diff(
        input logic [intra_pkg::pix_w-1:0] a,
        input logic [intra_pkg::pix_w-1:0] b
    );
        logic [intra_pkg::pix_w-1:0] d;
        d = (a > b) ? a - b : b - a;
        return 16'(d) * 16'(d);
    endfunction

    // Stage one
    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < intra_pkg::num_pix; i++) begin
                sq_q[i]  <= sq_diff(src[i], recon[i]);
                mag_q[i] <= intra_pkg::lvl_mag(levels[i]);
            end
        end
    end

    always_comb begin
        sse_sum  = '0;
        rate_sum = '0;
        for (int i = 0; i < intra_pkg::num_pix; i++) begin
            sse_sum  = sse_sum + sq_q[i];
            rate_sum = rate_sum + mag_q[i];
        end
    end

    // Stage two
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            sse  <= sse_sum;
            rate <= rate_sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= start;
            done     <= s1_valid;
        end
    end

endmodule

// ==== hdl/intra_mode_top.sv ====
/*
 * Luma intra mode decision engine
 * Valid/ready request and result ports around the mode picker,
 * the predictor, the residual quantizer and the metrics pipeline
 */

`timescale 1ns/1ns

module intra_mode_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  intra_pkg::intra_req_t  req,
    output logic                   req_ready,
    output logic                   res_valid,
    output intra_pkg::intra_res_t  res,
    input  logic                   res_ready,
    input  logic                   clear
);

    intra_pkg::intra_req_t             cur_req;
    logic                              pred_start;
    logic                              pred_done;
    intra_pkg::pix_blk_t               preds [intra_pkg::num_modes];
    logic                              quant_start;
    intra_pkg::pix_blk_t               quant_pred;
    logic                              quant_done;
    intra_pkg::pix_blk_t               recon;
    intra_pkg::lvl_blk_t               levels;
    logic [intra_pkg::num_pix-1:0]     nz;
    logic                              metrics_done;
    logic [intra_pkg::sse_w-1:0]       sse;
    logic [intra_pkg::rate_w-1:0]      rate;

    mode_picker u_picker (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .res_valid    (res_valid),
        .res          (res),
        .res_ready    (res_ready),
        .clear        (clear),
        .cur_req      (cur_req),
        .pred_start   (pred_start),
        .pred_done    (pred_done),
        .preds        (preds),
        .quant_start  (quant_start),
        .quant_pred   (quant_pred),
        .quant_done   (quant_done),
        .recon        (recon),
        .levels       (levels),
        .nz           (nz),
        .metrics_done (metrics_done),
        .sse          (sse),
        .rate         (rate)
    );

    intra_predict u_predict (
        .clk   (clk),
        .rst_n (rst_n),
        .start (pred_start),
        .req   (cur_req),
        .preds (preds),
        .done  (pred_done)
    );

    residual_quant u_quant (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (quant_start),
        .src    (cur_req.src),
        .pred   (quant_pred),
        .qshift (cur_req.qshift),
        .recon  (recon),
        .levels (levels),
        .nz     (nz),
        .done   (quant_done)
    );

    // Metrics start straight off the quantizer done pulse
    block_metrics u_metrics (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (quant_done),
        .src    (cur_req.src),
        .recon  (recon),
        .levels (levels),
        .sse    (sse),
        .rate   (rate),
        .done   (metrics_done)
    );

endmodule

// ==== hdl/intra_predict.sv ====
/*
 * Intra predictor
 * Builds the DC, TrueMotion, Vertical and Horizontal 4x4
 * predictions from the neighbour pixels and registers all
 * four on start. DC edge availability follows the block position
 */

`timescale 1ns/1ns

module intra_predict (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  intra_pkg::intra_req_t  req,
    output intra_pkg::pix_blk_t    preds [intra_pkg::num_modes],
    output logic                   done
);

    logic [intra_pkg::pix_w+1:0] sum_top;
    logic [intra_pkg::pix_w+1:0] sum_left;
    logic [intra_pkg::pix_w+2:0] sum_all;
    logic [intra_pkg::pix_w-1:0] dc_val;
    intra_pkg::pix_blk_t         pred_dc;
    intra_pkg::pix_blk_t         pred_tm;
    intra_pkg::pix_blk_t         pred_ve;
    intra_pkg::pix_blk_t         pred_he;

    // ------------------------------------------------------------
    // DC value
    // ------------------------------------------------------------
    always_comb begin
        sum_top  = '0;
        sum_left = '0;
        for (int i = 0; i < intra_pkg::blk_dim; i++) begin
            sum_top  = sum_top + req.top[i];
            sum_left = sum_left + req.left[i];
        end
    end

    assign sum_all = sum_top + sum_left + 11'd4;

    always_comb begin
        if (req.blk_x != '0 && req.blk_y != '0) begin
            dc_val = sum_all[intra_pkg::pix_w+2:3];
        end else if (req.blk_y != '0) begin
            dc_val = 8'((sum_top + 10'd2) >> 2);
        end else if (req.blk_x != '0) begin
            dc_val = 8'((sum_left + 10'd2) >> 2);
        end else begin
            dc_val = 8'd128;
        end
    end

    // ------------------------------------------------------------
    // Per pixel predictions
    // ------------------------------------------------------------
    for (genvar r = 0; r < intra_pkg::blk_dim; r++) begin : g_row
        for (genvar c = 0; c < intra_pkg::blk_dim; c++) begin : g_col
            logic signed [intra_pkg::pix_w+1:0] tm;

            // left + top - top_left
            assign tm = $signed({2'b00, req.left[r]}) + $signed({2'b00, req.top[c]})
                      - $signed({2'b00, req.top_left});

            assign pred_tm[r*intra_pkg::blk_dim+c] = tm[intra_pkg::pix_w+1] ? 8'd0 :
                                                     tm[intra_pkg::pix_w]   ? 8'd255 :
                                                     tm[intra_pkg::pix_w-1:0];
            assign pred_dc[r*intra_pkg::blk_dim+c] = dc_val;
            assign pred_ve[r*intra_pkg::blk_dim+c] = req.top[c];
            assign pred_he[r*intra_pkg::blk_dim+c] = req.left[r];
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            preds[intra_pkg::mode_dc] <= pred_dc;
            preds[intra_pkg::mode_tm] <= pred_tm;
            preds[intra_pkg::mode_ve] <= pred_ve;
            preds[intra_pkg::mode_he] <= pred_he;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    a_done_after_start: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(done) |-> $past(start)
    );

endmodule

// ==== hdl/mode_picker.sv ====
/*
 * Intra mode picker
 * Accepts a request, runs prediction, reconstruction, metrics
 * and scoring for modes 3 down to 0, keeps the best candidate,
 * rescores it with lambda_mode and holds the result until taken.
 * Also tracks the max_edge statistic across blocks
 */

`timescale 1ns/1ns

module mode_picker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req_valid,
    input  intra_pkg::intra_req_t             req,
    output logic                              req_ready,
    output logic                              res_valid,
    output intra_pkg::intra_res_t             res,
    input  logic                              res_ready,
    input  logic                              clear,
    output intra_pkg::intra_req_t             cur_req,
    output logic                              pred_start,
    input  logic                              pred_done,
    input  intra_pkg::pix_blk_t               preds [intra_pkg::num_modes],
    output logic                              quant_start,
    output intra_pkg::pix_blk_t               quant_pred,
    input  logic                              quant_done,
    input  intra_pkg::pix_blk_t               recon,
    input  intra_pkg::lvl_blk_t               levels,
    input  logic [intra_pkg::num_pix-1:0]     nz,
    input  logic                              metrics_done,
    input  logic [intra_pkg::sse_w-1:0]       sse,
    input  logic [intra_pkg::rate_w-1:0]      rate
);

    typedef enum logic [7:0] {
        st_idle   = 8'h01,
        st_pred   = 8'h02,
        st_quant  = 8'h04,
        st_metric = 8'h08,
        st_score  = 8'h10,
        st_comp   = 8'h20,
        st_final  = 8'h40,
        st_hold   = 8'h80
    } state_t;

    state_t                              state;
    logic                                got_req;
    logic [2:0]                          eval_cnt;
    intra_pkg::mode_t                    cur_mode;
    intra_pkg::intra_req_t               cur_req_q;
    logic [intra_pkg::rate_w-1:0]        rate_tot;
    logic [intra_pkg::rate_w-1:0]        cand_rate;
    logic [intra_pkg::score_w-1:0]       cand_score;
    logic [intra_pkg::rate_w-1:0]        best_rate;
    logic [intra_pkg::sse_w-1:0]         best_sse;
    intra_pkg::intra_res_t               res_q;
    logic [intra_pkg::lvl_w-1:0]         edge_q;
    logic [intra_pkg::lvl_w-1:0]         edge_new;

    function automatic logic [intra_pkg::score_w-1:0] calc_score(
        input logic [intra_pkg::rate_w-1:0]   r,
        input logic [intra_pkg::lambda_w-1:0] lam,
        input logic [intra_pkg::sse_w-1:0]    d
    );
        return (48'(r) << 10) * 48'(lam) + (48'(d) << 8);
    endfunction

    assign req_ready   = (state == st_idle) && !got_req;
    assign res_valid   = (state == st_hold);
    assign res         = res_q;
    assign cur_req     = cur_req_q;
    assign pred_start  = (state == st_pred);
    assign quant_start = (state == st_quant) && pred_done;

    // Modes run from 3 down to 0
    assign cur_mode   = intra_pkg::mode_t'(2'(intra_pkg::mode_he - eval_cnt[1:0]));
    assign quant_pred = preds[cur_mode];
    assign rate_tot   = rate + intra_pkg::fixed_cost[cur_mode];

    // ------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            got_req  <= 1'b0;
            eval_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    got_req  <= req_valid && req_ready;
                    eval_cnt <= '0;
                    if (got_req) begin
                        state <= st_pred;
                    end
                end
                st_pred: state <= st_quant;
                st_quant: begin
                    if (pred_done) begin
                        state <= st_metric;
                    end
                end
                // Second metrics cycle starts once quant_done has dropped
                st_metric: begin
                    if (!quant_done) begin
                        state <= st_score;
                    end
                end
                st_score: begin
                    if (metrics_done) begin
                        state <= st_comp;
                    end
                end
                st_comp: begin
                    eval_cnt <= eval_cnt + 3'd1;
                    if (eval_cnt == 3'(intra_pkg::num_modes - 1)) begin
                        state <= st_final;
                    end else begin
                        state <= st_pred;
                    end
                end
                st_final: state <= st_hold;
                st_hold: begin
                    if (res_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Candidate scoring and best keeping
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur_req_q <= req;
        end
        if (state == st_score && metrics_done) begin
            cand_rate  <= rate_tot;
            cand_score <= calc_score(rate_tot, cur_req_q.lambda_i16, sse);
        end
        // Ties go to the later, lower mode code
        if (state == st_comp && (eval_cnt == '0 || cand_score <= res_q.score)) begin
            res_q.mode   <= cur_mode;
            res_q.score  <= cand_score;
            res_q.recon  <= recon;
            res_q.levels <= levels;
            res_q.nz     <= nz;
            best_rate    <= cand_rate;
            best_sse     <= sse;
        end
        if (state == st_final) begin
            res_q.score    <= calc_score(best_rate, cur_req_q.lambda_mode, best_sse);
            res_q.max_edge <= edge_new;
        end
    end

    // max_edge from levels 1, 2 and 4 of a fully non-zero block
    always_comb begin
        edge_new = edge_q;
        if (&res_q.nz && best_sse > cur_req_q.min_disto) begin
            for (int i = 1; i <= 4; i = i * 2) begin
                if (intra_pkg::lvl_mag(res_q.levels[i]) > edge_new) begin
                    edge_new = intra_pkg::lvl_mag(res_q.levels[i]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_q <= '0;
        end else if (clear) begin
            edge_q <= '0;
        end else if (state == st_final) begin
            edge_q <= edge_new;
        end
    end

    a_res_stable: assert property (
        @(posedge clk) disable iff (!rst_n) res_valid && !res_ready |=> $stable(res)
    );

    a_mode_cnt_bound: assert property (
        @(posedge clk) disable iff (!rst_n) eval_cnt <= 3'(intra_pkg::num_modes)
    );

endmodule

// ==== reconstruct/residual_quant.sv ====
/*
 * Residual quantizer and reconstruction
 * Quantizes source minus prediction with a rounding power of
 * two step, rebuilds and clips the pixels, and flags non-zero
 * levels. One register stage
 */

`timescale 1ns/1ns

module residual_quant (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  intra_pkg::pix_blk_t                 src,
    input  intra_pkg::pix_blk_t                 pred,
    input  logic [intra_pkg::qshift_w-1:0]      qshift,
    output intra_pkg::pix_blk_t                 recon,
    output intra_pkg::lvl_blk_t                 levels,
    output logic [intra_pkg::num_pix-1:0]       nz,
    output logic                                done
);

    logic [intra_pkg::pix_w:0]          half;
    intra_pkg::pix_blk_t                recon_d;
    intra_pkg::lvl_blk_t                levels_d;
    logic [intra_pkg::num_pix-1:0]      nz_d;
    logic [intra_pkg::num_pix-1:0]      keep_ok;

    // Rounding offset, half a step
    assign half = 9'((9'd1 << qshift) >> 1);

    for (genvar i = 0; i < intra_pkg::num_pix; i++) begin : g_pix
        logic signed [intra_pkg::pix_w+1:0]  diff;
        logic [intra_pkg::pix_w:0]           mag;
        logic [intra_pkg::pix_w:0]           qmag;
        logic signed [intra_pkg::lvl_w-1:0]  lvl;
        logic signed [intra_pkg::pix_w+3:0]  dq;
        logic signed [intra_pkg::pix_w+3:0]  rec;

        assign diff = $signed({2'b00, src[i]}) - $signed({2'b00, pred[i]});
        assign mag  = diff[intra_pkg::pix_w+1] ? 9'(-diff) : diff[intra_pkg::pix_w:0];
        assign qmag = (mag + half) >> qshift;
        assign lvl  = diff[intra_pkg::pix_w+1] ? -$signed({1'b0, qmag}) : $signed({1'b0, qmag});

        // Dequantize and add back the prediction
        assign dq  = lvl;
        assign rec = $signed({4'b0000, pred[i]}) + (dq <<< qshift);

        assign recon_d[i]  = rec[intra_pkg::pix_w+3] ? 8'd0 :
                             (rec > 12'sd255)        ? 8'd255 :
                             rec[intra_pkg::pix_w-1:0];
        assign levels_d[i] = lvl;
        assign nz_d[i]     = (qmag != '0);

        // Zero level must leave the prediction untouched
        assign keep_ok[i] = nz[i] || (recon[i] == pred[i]);
    end

    always_ff @(posedge clk) begin
        if (start) begin
            recon  <= recon_d;
            levels <= levels_d;
            nz     <= nz_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    // Picker keeps pred steady from start until done
    a_zero_level_keeps_pred: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> &keep_ok
    );

endmodule

// ==== tb/intra_golden.txt ====
# op name src top left top_left blk_x blk_y qshift lambda_mode lambda_i16 min_disto
#   exp_mode exp_score exp_recon exp_levels exp_nz exp_max_edge (all hex)
# Flat block, both edges, DC
block flat_nn 64646464646464646464646464646464 64646464 64646464 64 001 001 0 0002 0001 0000a 0 00000014b800 64646464646464646464646464646464 0000000000000000000000000000000000000000 0000 000
# Vertical stripes, Vertical
block vstripe C80AC80AC80AC80AC80AC80AC80AC80A C80AC80A 64646464 64 001 001 0 0002 0001 0000a 2 0000001b4000 C80AC80AC80AC80AC80AC80AC80AC80A 0000000000000000000000000000000000000000 0000 000
# Horizontal stripes, Horizontal
block hstripe C8C8C8C80A0A0A0AC8C8C8C80A0A0A0A 64646464 C80AC80A 5a 001 001 0 0002 0001 0000a 3 0000001cb800 C8C8C8C80A0A0A0AC8C8C8C80A0A0A0A 0000000000000000000000000000000000000000 0000 000
# TrueMotion and Horizontal tie, lower code wins
block tie_tm_he C8C8C8C80A0A0A0AC8C8C8C80A0A0A0A 64646464 C80AC80A 64 001 001 0 0002 0001 0000a 1 0000001cb800 C8C8C8C80A0A0A0AC8C8C8C80A0A0A0A 0000000000000000000000000000000000000000 0000 000
# Gradient, TrueMotion
block gradient A0968C82786E645A50463C32281E140A 281E140A 825A320A 0a 001 001 0 0002 0001 0000a 1 0000001cb800 A0968C82786E645A50463C32281E140A 0000000000000000000000000000000000000000 0000 000
# DC edge cases at (0,0), (0,n), (n,0)
block dc_00 80808080808080808080808080808080 32323232 3C3C3C3C 37 000 000 0 0002 0001 0000a 0 00000014b800 80808080808080808080808080808080 0000000000000000000000000000000000000000 0000 000
block dc_top 29292929292929292929292929292929 2C282828 C8C8C8C8 00 000 001 0 0002 0001 0000a 0 00000014b800 29292929292929292929292929292929 0000000000000000000000000000000000000000 0000 000
block dc_left 51515151515151515151515151515151 00000000 54505050 00 001 000 0 0002 0001 0000a 0 00000014b800 51515151515151515151515151515151 0000000000000000000000000000000000000000 0000 000
# Quantized blocks, max_edge grows to 15
block quant_a FAFAFAFAFAFAFAFAFAFAFAFAFAFAFAFA 00000000 00000000 00 000 000 3 0002 0001 0000a 0 0000001c7800 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 03C0F03C0F03C0F03C0F03C0F03C0F03C0F03C0F ffff 00f
# Upper clip, sse zero so max_edge unchanged
block clip_hi FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 00000000 00000000 00 000 000 3 0002 0001 0000a 0 0000001cb800 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0401004010040100401004010040100401004010 ffff 00f
# Lower clip, negative levels raise max_edge to 16
block clip_lo 02020202020202020202020202020202 FFFFFFFF FFFFFFFF ff 000 000 3 0002 0001 0000a 0 0000001cf800 00000000000000000000000000000000 FC3F0FC3F0FC3F0FC3F0FC3F0FC3F0FC3F0FC3F0 ffff 010
stall flat_hold 64646464646464646464646464646464 64646464 64646464 64 001 001 0 0002 0001 0000a 0 00000014b800 64646464646464646464646464646464 0000000000000000000000000000000000000000 0000 010
clear clr0
block flat_clr 64646464646464646464646464646464 64646464 64646464 64 001 001 0 0002 0001 0000a 0 00000014b800 64646464646464646464646464646464 0000000000000000000000000000000000000000 0000 000
stall vstripe_st C80AC80AC80AC80AC80AC80AC80AC80A C80AC80A 64646464 64 001 001 0 0002 0001 0000a 2 0000001b4000 C80AC80AC80AC80AC80AC80AC80AC80A 0000000000000000000000000000000000000000 0000 000
stall gradient_st A0968C82786E645A50463C32281E140A 281E140A 825A320A 0a 001 001 0 0002 0001 0000a 1 0000001cb800 A0968C82786E645A50463C32281E140A 0000000000000000000000000000000000000000 0000 000
stall quant_st FAFAFAFAFAFAFAFAFAFAFAFAFAFAFAFA 00000000 00000000 00 000 000 3 0002 0001 0000a 0 0000001c7800 F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8F8 03C0F03C0F03C0F03C0F03C0F03C0F03C0F03C0F ffff 00f

// ==== tb/tb_intra_mode.sv ====
/*
 * Testbench for the luma intra mode decision engine
 * Reads requests and expected results from the golden file,
 * applies random res_ready back-pressure on stall lines and
 * checks mode, score, recon, levels, nz and max_edge
 */

`timescale 1ns/1ns

module tb_intra_mode;

    localparam int rst_cycles = 16;
    localparam int cyc_per_line = 40;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    intra_pkg::intra_req_t  req;
    logic                   req_ready;
    logic                   res_valid;
    intra_pkg::intra_res_t  res;
    logic                   res_ready;
    logic                   clear;

    int          value_errors;
    int          proto_errors;
    int          cycle_cnt;
    int          cycle_limit;
    int          accepted;
    int          results_taken;
    int          blocks_sent;
    logic [31:0] lfsr;

    // Fields of one golden line
    string        op;
    string        name;
    logic [127:0] f_src;
    logic [31:0]  f_top;
    logic [31:0]  f_left;
    logic [7:0]   f_tl;
    logic [9:0]   f_bx;
    logic [9:0]   f_by;
    logic [2:0]   f_qs;
    logic [15:0]  f_lm;
    logic [15:0]  f_li;
    logic [19:0]  f_md;
    logic [1:0]   e_mode;
    logic [47:0]  e_score;
    logic [127:0] e_recon;
    logic [159:0] e_levels;
    logic [15:0]  e_nz;
    logic [9:0]   e_edge;

    intra_mode_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready),
        .clear     (clear)
    );

    always #10 clk = ~clk;

    // Run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Handshakes seen on the DUT ports
    always @(posedge clk) begin
        if (rst_n) begin
            if (req_valid && req_ready) begin
                accepted++;
            end
            if (res_valid && res_ready) begin
                results_taken++;
            end
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic compare_field(input string field, input logic [159:0] exp_v,
                                 input logic [159:0] act_v);
        assert (exp_v == act_v) else begin
            value_errors++;
            $display("ERROR %s %s: expected %h, actual %h", name, field, exp_v, act_v);
        end
    endtask

    task automatic protocol_check(input logic ok, input string what);
        assert (ok) else begin
            proto_errors++;
            $display("Protocol failure in %s: %s", name, what);
        end
    endtask

    //------------------------------------------------------------
    // One block through the engine
    //------------------------------------------------------------
    task automatic run_block(input logic stall);
        intra_pkg::intra_res_t held;

        @(posedge clk);
        #2;
        req_valid       = 1'b1;
        req.src         = f_src;
        req.top         = f_top;
        req.left        = f_left;
        req.top_left    = f_tl;
        req.blk_x       = f_bx;
        req.blk_y       = f_by;
        req.qshift      = f_qs;
        req.lambda_mode = f_lm;
        req.lambda_i16  = f_li;
        req.min_disto   = f_md;
        res_ready       = !stall;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        blocks_sent++;

        @(negedge clk);
        while (!res_valid) begin
            protocol_check(!req_ready, "req_ready high while a block is in flight");
            @(negedge clk);
        end
        held = res;

        forever begin
            protocol_check(res == held, "res changed while waiting for res_ready");
            protocol_check(!req_ready, "req_ready high while the result is held");
            if (res_ready) begin
                break;
            end
            @(posedge clk);
            #2;
            lfsr = lfsr_next(lfsr);
            res_ready = stall ? lfsr[0] : 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        res_ready = 1'b0;
        @(negedge clk);
        protocol_check(!res_valid, "res_valid still high after the result was taken");

        compare_field("mode", 160'(e_mode), 160'(held.mode));
        compare_field("score", 160'(e_score), 160'(held.score));
        compare_field("recon", 160'(e_recon), 160'(held.recon));
        compare_field("levels", e_levels, 160'(held.levels));
        compare_field("nz", 160'(e_nz), 160'(held.nz));
        compare_field("max_edge", 160'(e_edge), 160'(held.max_edge));
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        #2;
        clear = 1'b1;
        @(posedge clk);
        #2;
        clear = 1'b0;
    endtask

    initial begin
        int    fd;
        int    n;
        int    lines;
        string line;

        clk           = 1'b0;
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        res_ready     = 1'b0;
        clear         = 1'b0;
        value_errors  = 0;
        proto_errors  = 0;
        cycle_cnt     = 0;
        cycle_limit   = 0;
        accepted      = 0;
        results_taken = 0;
        blocks_sent   = 0;
        lfsr          = 32'heb84_68a7;
        lines         = 0;

        // First pass sizes the cycle budget
        fd = $fopen("tb/intra_golden.txt", "r");
        if (fd == 0) begin
            proto_errors++;
            $display("Cannot open the golden file tb/intra_golden.txt");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 2 && line[0] != "#") begin
                    lines++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = lines * cyc_per_line + rst_cycles + 4;

        repeat (rst_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        protocol_check(req_ready && !res_valid, "wrong handshake levels after reset");

        fd = $fopen("tb/intra_golden.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd)) begin
                if (line.len() > 2 && line[0] != "#") begin
                    n = $sscanf(line,
                        "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        op, name, f_src, f_top, f_left, f_tl, f_bx, f_by, f_qs,
                        f_lm, f_li, f_md, e_mode, e_score, e_recon, e_levels,
                        e_nz, e_edge);
                    if (op == "clear") begin
                        pulse_clear();
                    end else if (n != 18) begin
                        proto_errors++;
                        $display("Malformed golden line for test %s", name);
                    end else if (op == "stall") begin
                        run_block(1'b1);
                    end else begin
                        run_block(1'b0);
                    end
                end
            end
            $fclose(fd);
        end

        protocol_check(accepted == blocks_sent, "accepted request count differs from blocks sent");
        protocol_check(results_taken == blocks_sent, "result count differs from blocks sent");

        $display("Value errors: %0d, protocol errors: %0d, results: %0d",
                 value_errors, proto_errors, results_taken);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
